// File: design/cache_consts.svh
// Geometry constants for one cache bank, with derived field widths
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Associativity and number of sets in each way
`define CACHE_NUM_WAYS       4
`define CACHE_NUM_LINES      16

// Line layout
`define CACHE_WORDS_PER_LINE 4
`define CACHE_WORD_BITS      32

// Word address seen by the core
`define CACHE_ADDR_BITS      12

// Derived widths
`define CACHE_WAY_BITS       $clog2(`CACHE_NUM_WAYS)
`define CACHE_IDX_BITS       $clog2(`CACHE_NUM_LINES)
`define CACHE_OFF_BITS       $clog2(`CACHE_WORDS_PER_LINE)
`define CACHE_TAG_BITS       (`CACHE_ADDR_BITS - `CACHE_IDX_BITS - `CACHE_OFF_BITS)

`endif

// File: design/cache_addr_pkg.sv
// Address field types that split a word address into tag, set index and word offset
`include "cache_consts.svh"

package cache_addr_pkg;

    // Field types
    typedef logic [`CACHE_TAG_BITS-1:0] tag_t;
    typedef logic [`CACHE_IDX_BITS-1:0] line_idx_t;
    typedef logic [`CACHE_OFF_BITS-1:0] word_off_t;

    // One bit per way, one-hot where a single way is meant
    typedef logic [`CACHE_NUM_WAYS-1:0] way_mask_t;

    // Full word address, tag in the upper bits
    typedef struct packed {
        tag_t      tag;
        line_idx_t idx;
        word_off_t off;
    } word_addr_t;

    // Address of a whole line, as sent to memory
    typedef struct packed {
        tag_t      tag;
        line_idx_t idx;
    } line_addr_t;

endpackage

// File: design/cache_req_pkg.sv
// Core request and response types and memory transfer types of the cache bank
`include "cache_consts.svh"

package cache_req_pkg;

    typedef enum logic [1:0] {
        OP_READ  = 2'd0,
        OP_WRITE = 2'd1,
        OP_FLUSH = 2'd2
    } cache_op_t;

    typedef logic [`CACHE_WORD_BITS-1:0] word_t;

    // Word 0 sits in the low bits
    typedef logic [`CACHE_WORDS_PER_LINE-1:0][`CACHE_WORD_BITS-1:0] line_data_t;

    // Flush uses only the index of addr, together with the way mask
    typedef struct packed {
        cache_op_t                 op;
        cache_addr_pkg::word_addr_t addr;
        word_t                     wdata;
        cache_addr_pkg::way_mask_t flush_mask;
    } core_req_t;

    typedef struct packed {
        word_t rdata;
        logic  hit;
    } core_rsp_t;

    typedef struct packed {
        logic                      write;
        cache_addr_pkg::line_addr_t addr;
        line_data_t                data;
    } mem_req_t;

endpackage

// File: design/cache_tags.sv
// Tag store with per-way valid, dirty and tag, hit match and round-robin victim choice
`include "cache_consts.svh"

module cache_tags (
    input  logic                       clk,
    input  logic                       reset,

    input  logic                       init,
    input  logic                       flush,
    input  logic                       fill,
    input  logic                       write,
    input  logic                       lookup,
    input  cache_addr_pkg::line_addr_t line_addr,
    input  cache_addr_pkg::way_mask_t  way_idx,
    output cache_addr_pkg::way_mask_t  tag_matches,

    output logic                       evict_dirty,
    output cache_addr_pkg::way_mask_t  evict_way,
    output cache_addr_pkg::tag_t       evict_tag
);
    import cache_addr_pkg::*;

    line_idx_t line_idx;
    tag_t      line_tag;

    // One entry per set, bit w of an entry belongs to way w
    way_mask_t valid_q [`CACHE_NUM_LINES];
    way_mask_t dirty_q [`CACHE_NUM_LINES];
    tag_t      tag_q   [`CACHE_NUM_WAYS][`CACHE_NUM_LINES];

    way_mask_t read_valid;
    way_mask_t read_dirty;

    // Round-robin pointer, one-hot
    way_mask_t rr_q;
    way_mask_t rr_next;

    assign line_idx   = line_addr.idx;
    assign line_tag   = line_addr.tag;
    assign read_valid = valid_q[line_idx];
    assign read_dirty = dirty_q[line_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            rr_q <= way_mask_t'(1);
        end else if (lookup) begin
            rr_q <= rr_next;
        end
    end

    assign rr_next = {rr_q[`CACHE_NUM_WAYS-2:0], rr_q[`CACHE_NUM_WAYS-1]};

    // The fill uses the pointer as victim. A lookup reports the way the
    // pointer moves to, so the miss sees its victim before the refill
    assign evict_way = lookup ? rr_next : (fill ? rr_q : way_idx);

    always_comb begin
        evict_tag = '0;
        for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
            tag_matches[w] = read_valid[w] && (tag_q[w][line_idx] == line_tag);
            if (evict_way[w]) begin
                evict_tag = evict_tag | tag_q[w][line_idx];
            end
        end
    end

    assign evict_dirty = |(read_valid & read_dirty & evict_way);

    // Init clears every way of a set, flush only the named ways
    always_ff @(posedge clk) begin
        for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
            if (init || (flush && way_idx[w])) begin
                valid_q[line_idx][w] <= 1'b0;
                dirty_q[line_idx][w] <= 1'b0;
            end else if (fill && evict_way[w]) begin
                valid_q[line_idx][w] <= 1'b1;
                dirty_q[line_idx][w] <= write;
                tag_q[w][line_idx]   <= line_tag;
            end else if (lookup && write && tag_matches[w]) begin
                // Write hit
                dirty_q[line_idx][w] <= 1'b1;
            end
        end
    end

endmodule

// File: design/cache_data.sv
// Data store holding one line per way and set, with line fill and single-word write
`include "cache_consts.svh"

module cache_data (
    input  logic                             clk,

    input  cache_addr_pkg::line_idx_t        line_idx,
    input  cache_addr_pkg::way_mask_t        way_sel,

    input  logic                             fill,
    input  cache_req_pkg::line_data_t        fill_line,

    input  logic                             word_write,
    input  logic [`CACHE_OFF_BITS-1:0]       word_offset,
    input  logic [`CACHE_WORD_BITS-1:0]      word_data,

    output cache_req_pkg::line_data_t        read_line
);
    import cache_req_pkg::*;

    line_data_t lines_q [`CACHE_NUM_WAYS][`CACHE_NUM_LINES];

    // A word write in the same cycle as a fill lands on top of the new line
    always_ff @(posedge clk) begin
        for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
            if (way_sel[w]) begin
                if (fill) begin
                    lines_q[w][line_idx] <= fill_line;
                end
                if (word_write) begin
                    lines_q[w][line_idx][word_offset] <= word_data;
                end
            end
        end
    end

    // One-hot select, zero when no way is selected
    always_comb begin
        read_line = '0;
        for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
            if (way_sel[w]) begin
                read_line = read_line | lines_q[w][line_idx];
            end
        end
    end

endmodule

// File: design/cache_bank_ctrl.sv
// Bank FSM for init sweep, lookup, writeback, refill, flush and core response
`include "cache_consts.svh"

module cache_bank_ctrl (
    input  logic                         clk,
    input  logic                         reset,

    input  logic                         core_req_valid,
    input  cache_req_pkg::core_req_t     core_req,
    output logic                         busy,
    output logic                         core_rsp_valid,
    output cache_req_pkg::core_rsp_t     core_rsp,

    output logic                         mem_req_valid,
    output cache_req_pkg::mem_req_t      mem_req,
    input  logic                         mem_rsp_valid,

    output logic                         tag_init,
    output logic                         tag_flush,
    output logic                         tag_fill,
    output logic                         tag_write,
    output logic                         tag_lookup,
    output cache_addr_pkg::line_addr_t   tag_line_addr,
    output cache_addr_pkg::way_mask_t    tag_way_idx,
    input  cache_addr_pkg::way_mask_t    tag_matches,
    input  logic                         evict_dirty,
    input  cache_addr_pkg::way_mask_t    evict_way,
    input  cache_addr_pkg::tag_t         evict_tag,

    output cache_addr_pkg::line_idx_t    data_line_idx,
    output cache_addr_pkg::way_mask_t    data_way_sel,
    output logic                         data_fill,
    output logic                         data_word_write,
    output logic [`CACHE_OFF_BITS-1:0]   data_word_offset,
    output logic [`CACHE_WORD_BITS-1:0]  data_word_data,
    input  cache_req_pkg::line_data_t    read_line
);
    import cache_addr_pkg::*;
    import cache_req_pkg::*;

    typedef enum logic [2:0] {
        S_INIT, S_IDLE, S_LOOKUP, S_WBACK, S_FILL_REQ, S_FILL_WAIT, S_RESP, S_FLUSH
    } state_t;

    state_t    state_q;
    state_t    state_d;
    core_req_t req_q;
    line_idx_t init_cnt_q;
    logic [`CACHE_WAY_BITS-1:0] flush_cnt_q;
    way_mask_t victim_way_q;
    tag_t      victim_tag_q;

    logic      hit;
    logic      is_write;
    logic      fill_now;
    logic      flush_sel;
    way_mask_t flush_way;

    assign hit       = |tag_matches;
    assign is_write  = (req_q.op == OP_WRITE);
    assign fill_now  = (state_q == S_FILL_WAIT) && mem_rsp_valid;
    assign flush_way = way_mask_t'(1) << flush_cnt_q;
    assign flush_sel = req_q.flush_mask[flush_cnt_q];

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_INIT:      if (init_cnt_q == line_idx_t'(`CACHE_NUM_LINES - 1)) state_d = S_IDLE;
            S_IDLE: begin
                if (core_req_valid) begin
                    state_d = (core_req.op == OP_FLUSH) ? S_FLUSH : S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (hit) begin
                    state_d = S_IDLE;
                end else begin
                    state_d = evict_dirty ? S_WBACK : S_FILL_REQ;
                end
            end
            S_WBACK:     state_d = S_FILL_REQ;
            S_FILL_REQ:  state_d = S_FILL_WAIT;
            S_FILL_WAIT: if (mem_rsp_valid) state_d = S_RESP;
            S_RESP:      state_d = S_IDLE;
            S_FLUSH:     if (int'(flush_cnt_q) == `CACHE_NUM_WAYS - 1) state_d = S_RESP;
            default:     state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q    <= S_INIT;
            init_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == S_INIT) begin
                init_cnt_q <= init_cnt_q + 1'b1;
            end
        end
    end

    // Request and victim bookkeeping
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && core_req_valid) begin
            req_q       <= core_req;
            flush_cnt_q <= '0;
        end
        if (state_q == S_FLUSH) begin
            flush_cnt_q <= flush_cnt_q + 1'b1;
        end
        if (state_q == S_LOOKUP && !hit) begin
            victim_way_q <= evict_way;
            victim_tag_q <= evict_tag;
        end
    end

    assign busy = (state_q != S_IDLE);

    // Tag store controls
    assign tag_init          = (state_q == S_INIT);
    assign tag_lookup        = (state_q == S_LOOKUP);
    assign tag_fill          = fill_now;
    assign tag_write         = is_write && (tag_lookup || fill_now);
    assign tag_flush         = (state_q == S_FLUSH) && flush_sel;
    assign tag_line_addr.tag = req_q.addr.tag;
    assign tag_line_addr.idx = (state_q == S_INIT) ? init_cnt_q : req_q.addr.idx;
    assign tag_way_idx       = (state_q == S_FLUSH) ? flush_way : victim_way_q;

    // Data store controls
    always_comb begin
        case (state_q)
            S_LOOKUP: data_way_sel = tag_matches;
            S_FLUSH:  data_way_sel = flush_way;
            default:  data_way_sel = victim_way_q;
        endcase
    end

    assign data_line_idx    = req_q.addr.idx;
    assign data_fill        = fill_now;
    assign data_word_write  = is_write && ((tag_lookup && hit) || fill_now);
    assign data_word_offset = req_q.addr.off;
    assign data_word_data   = req_q.wdata;

    // Core response with hit set only straight out of the lookup
    assign core_rsp_valid = (tag_lookup && hit) || (state_q == S_RESP);
    assign core_rsp.rdata = read_line[req_q.addr.off];
    assign core_rsp.hit   = tag_lookup;

    // Memory side where writebacks carry the selected line
    assign mem_req_valid = (state_q == S_WBACK) || (state_q == S_FILL_REQ)
                         || ((state_q == S_FLUSH) && flush_sel && evict_dirty);

    always_comb begin
        mem_req.write    = (state_q != S_FILL_REQ);
        mem_req.addr.idx = req_q.addr.idx;
        mem_req.data     = read_line;
        case (state_q)
            S_FILL_REQ: mem_req.addr.tag = req_q.addr.tag;
            S_FLUSH:    mem_req.addr.tag = evict_tag;
            default:    mem_req.addr.tag = victim_tag_q;
        endcase
    end

endmodule

// File: design/cache_bank.sv
// One write-back cache bank built from controller, tag store and data store
`include "cache_consts.svh"

module cache_bank (
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      core_req_valid,
    input  cache_req_pkg::core_req_t  core_req,
    output logic                      busy,
    output logic                      core_rsp_valid,
    output cache_req_pkg::core_rsp_t  core_rsp,

    output logic                      mem_req_valid,
    output cache_req_pkg::mem_req_t   mem_req,
    input  logic                      mem_rsp_valid,
    input  cache_req_pkg::line_data_t mem_rsp_data
);
    import cache_addr_pkg::*;
    import cache_req_pkg::*;

    // Controller to tag store
    logic       tag_init;
    logic       tag_flush;
    logic       tag_fill;
    logic       tag_write;
    logic       tag_lookup;
    line_addr_t tag_line_addr;
    way_mask_t  tag_way_idx;
    way_mask_t  tag_matches;
    logic       evict_dirty;
    way_mask_t  evict_way;
    tag_t       evict_tag;

    // Controller to data store
    line_idx_t                   data_line_idx;
    way_mask_t                   data_way_sel;
    logic                        data_fill;
    logic                        data_word_write;
    logic [`CACHE_OFF_BITS-1:0]  data_word_offset;
    logic [`CACHE_WORD_BITS-1:0] data_word_data;
    line_data_t                  read_line;

    cache_bank_ctrl i_ctrl (
        .clk              (clk),
        .reset            (reset),
        .core_req_valid   (core_req_valid),
        .core_req         (core_req),
        .busy             (busy),
        .core_rsp_valid   (core_rsp_valid),
        .core_rsp         (core_rsp),
        .mem_req_valid    (mem_req_valid),
        .mem_req          (mem_req),
        .mem_rsp_valid    (mem_rsp_valid),
        .tag_init         (tag_init),
        .tag_flush        (tag_flush),
        .tag_fill         (tag_fill),
        .tag_write        (tag_write),
        .tag_lookup       (tag_lookup),
        .tag_line_addr    (tag_line_addr),
        .tag_way_idx      (tag_way_idx),
        .tag_matches      (tag_matches),
        .evict_dirty      (evict_dirty),
        .evict_way        (evict_way),
        .evict_tag        (evict_tag),
        .data_line_idx    (data_line_idx),
        .data_way_sel     (data_way_sel),
        .data_fill        (data_fill),
        .data_word_write  (data_word_write),
        .data_word_offset (data_word_offset),
        .data_word_data   (data_word_data),
        .read_line        (read_line)
    );

    cache_tags i_tags (
        .clk         (clk),
        .reset       (reset),
        .init        (tag_init),
        .flush       (tag_flush),
        .fill        (tag_fill),
        .write       (tag_write),
        .lookup      (tag_lookup),
        .line_addr   (tag_line_addr),
        .way_idx     (tag_way_idx),
        .tag_matches (tag_matches),
        .evict_dirty (evict_dirty),
        .evict_way   (evict_way),
        .evict_tag   (evict_tag)
    );

    // Refill data comes straight from the memory response
    cache_data i_data (
        .clk         (clk),
        .line_idx    (data_line_idx),
        .way_sel     (data_way_sel),
        .fill        (data_fill),
        .fill_line   (mem_rsp_data),
        .word_write  (data_word_write),
        .word_offset (data_word_offset),
        .word_data   (data_word_data),
        .read_line   (read_line)
    );

endmodule

// File: test/cache_bank_properties.sv
// Protocol assertions for the cache bank core and memory ports
`include "cache_consts.svh"

module cache_bank_properties (
    input logic                    clk,
    input logic                    reset,
    input logic                    busy,
    input logic                    core_req_valid,
    input logic                    core_rsp_valid,
    input logic                    mem_req_valid,
    input cache_req_pkg::mem_req_t mem_req,
    input logic                    mem_rsp_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    logic        read_issue;
    logic        read_pending;
    int unsigned assert_fails = 0;

    assign read_issue = mem_req_valid && !mem_req.write;

    // Set by a refill read, cleared by its response
    always_ff @(posedge clk) begin
        if (reset) begin
            read_pending <= 1'b0;
        end else if (read_issue) begin
            read_pending <= 1'b1;
        end else if (mem_rsp_valid) begin
            read_pending <= 1'b0;
        end
    end

    req_while_idle: assert property (@(posedge clk) disable iff (reset)
        core_req_valid |-> !busy)
        else begin
            assert_fails++;
            $error("core request strobe while the bank was busy");
        end

    rsp_ends_busy: assert property (@(posedge clk) disable iff (reset)
        core_rsp_valid |-> busy ##1 !busy)
        else begin
            assert_fails++;
            $error("response not inside a busy period that ends right after it");
        end

    single_read: assert property (@(posedge clk) disable iff (reset)
        read_issue |-> !read_pending)
        else begin
            assert_fails++;
            $error("second memory read before the first was answered");
        end

    init_busy: assert property (@(posedge clk)
        $fell(reset) |-> busy [* `CACHE_NUM_LINES] ##1 !busy)
        else begin
            assert_fails++;
            $error("busy did not cover exactly the init sweep");
        end

endmodule

bind cache_bank cache_bank_properties i_props (
    .clk            (clk),
    .reset          (reset),
    .busy           (busy),
    .core_req_valid (core_req_valid),
    .core_rsp_valid (core_rsp_valid),
    .mem_req_valid  (mem_req_valid),
    .mem_req        (mem_req),
    .mem_rsp_valid  (mem_rsp_valid)
);

// File: test/cache_bank_tb.sv
// Cache bank testbench with random traffic, a random-latency memory model and a reference model
`include "cache_consts.svh"

module cache_bank_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import cache_addr_pkg::*;
    import cache_req_pkg::*;

    localparam int NUM_WORDS   = 1 << `CACHE_ADDR_BITS;
    localparam int INIT_READS  = 4;
    localparam int RAND_READS  = 150;
    localparam int RAND_WRITES = 100;
    localparam int MIXED_OPS   = 600;
    localparam int TOTAL_REQS  = INIT_READS + RAND_READS + 2 * RAND_WRITES + 5 + 3
                                 + MIXED_OPS + `CACHE_NUM_LINES;
    // Issue, lookup, writeback, read request, up to 8 wait cycles, response
    localparam int MISS_CYCLES = 13;
    localparam int WATCHDOG_NS = 4 * (TOTAL_REQS * MISS_CYCLES + `CACHE_NUM_LINES + 10);

    logic       clk;
    logic       reset;
    logic       core_req_valid;
    core_req_t  core_req;
    logic       busy;
    logic       core_rsp_valid;
    core_rsp_t  core_rsp;
    logic       mem_req_valid;
    mem_req_t   mem_req;
    logic       mem_rsp_valid;
    line_data_t mem_rsp_data;

    // Data as the core must see it, and the memory behind the bank
    word_t arch_mem [NUM_WORDS];
    word_t back_mem [NUM_WORDS];

    // Mirror of the tag store
    logic ref_valid [`CACHE_NUM_LINES][`CACHE_NUM_WAYS];
    logic ref_dirty [`CACHE_NUM_LINES][`CACHE_NUM_WAYS];
    tag_t ref_tag   [`CACHE_NUM_LINES][`CACHE_NUM_WAYS];
    int   ref_rr;

    // Memory requests the bank should issue next (address and write flag only)
    mem_req_t    exp_mem_ops [$];
    int unsigned latencies [256];
    logic        rd_pending;
    int          rd_wait;
    line_addr_t  rd_addr;
    int          mem_reads;
    int          mem_writes;
    int          checks;
    int          errors;

    cache_bank i_cache_bank (
        .clk            (clk),
        .reset          (reset),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .busy           (busy),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_data   (mem_rsp_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(logic cond, string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("at %0d ns %s", $time, what);
        end
    endtask

    function automatic word_t fill_pattern(int addr);
        return (word_t'(addr) * 32'h9e3779b1) ^ 32'h5bd1e995;
    endfunction

    function automatic word_addr_t rand_addr(int tags, int idx_lo, int idxs);
        word_addr_t a;
        a.tag = tag_t'($urandom_range(tags - 1, 0));
        a.idx = line_idx_t'(idx_lo + $urandom_range(idxs - 1, 0));
        a.off = word_off_t'($urandom_range(`CACHE_WORDS_PER_LINE - 1, 0));
        return a;
    endfunction

    function automatic mem_req_t mem_op(logic write, tag_t tag, line_idx_t idx);
        mem_req_t op;
        op          = '0;
        op.write    = write;
        op.addr.tag = tag;
        op.addr.idx = idx;
        return op;
    endfunction

    // Mirrors one request in the reference model and returns the expected hit flag
    function automatic logic predict(core_req_t req);
        word_addr_t a;
        logic       hit;
        a   = req.addr;
        hit = 1'b0;
        if (req.op == OP_FLUSH) begin
            for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
                if (req.flush_mask[w]) begin
                    if (ref_valid[a.idx][w] && ref_dirty[a.idx][w]) begin
                        exp_mem_ops.push_back(mem_op(1'b1, ref_tag[a.idx][w], a.idx));
                    end
                    ref_valid[a.idx][w] = 1'b0;
                    ref_dirty[a.idx][w] = 1'b0;
                end
            end
            return 1'b0;
        end
        // The pointer moves on every lookup and a miss takes the way it moves to
        ref_rr = (ref_rr + 1) % `CACHE_NUM_WAYS;
        for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
            if (ref_valid[a.idx][w] && ref_tag[a.idx][w] == a.tag) begin
                hit = 1'b1;
                if (req.op == OP_WRITE) begin
                    ref_dirty[a.idx][w] = 1'b1;
                end
            end
        end
        if (!hit) begin
            if (ref_valid[a.idx][ref_rr] && ref_dirty[a.idx][ref_rr]) begin
                exp_mem_ops.push_back(mem_op(1'b1, ref_tag[a.idx][ref_rr], a.idx));
            end
            exp_mem_ops.push_back(mem_op(1'b0, a.tag, a.idx));
            ref_valid[a.idx][ref_rr] = 1'b1;
            ref_dirty[a.idx][ref_rr] = (req.op == OP_WRITE);
            ref_tag[a.idx][ref_rr]   = a.tag;
        end
        if (req.op == OP_WRITE) begin
            arch_mem[a] = req.wdata;
        end
        return hit;
    endfunction

    // Entered 1 ns after a rising edge and returns 1 ns into the response cycle
    task automatic issue(input cache_op_t op, input word_addr_t addr, input word_t wdata,
                         input way_mask_t mask, output logic hit);
        core_req_t req;
        logic      exp_hit;
        word_t     exp_data;
        int        lat;
        req.op         = op;
        req.addr       = addr;
        req.wdata      = wdata;
        req.flush_mask = mask;
        exp_data       = arch_mem[addr];
        exp_hit        = predict(req);
        while (busy) begin
            @(posedge clk);
            #1;
        end
        core_req_valid = 1'b1;
        core_req       = req;
        @(posedge clk);
        #1;
        core_req_valid = 1'b0;
        lat = 1;
        while (!core_rsp_valid) begin
            @(posedge clk);
            #1;
            lat++;
        end
        hit = core_rsp.hit;
        check_value("core_rsp.hit", hit, exp_hit);
        if (op == OP_READ) begin
            check_value("core_rsp.rdata", core_rsp.rdata, exp_data);
        end
        if (exp_hit) begin
            check_value("hit latency", lat, 1);
        end
        check_true(exp_mem_ops.size() == 0, "an expected memory request never came");
        exp_mem_ops.delete();
    endtask

    task automatic serve_memory(mem_req_t op);
        mem_req_t exp;
        int       base;
        base = int'(op.addr) * `CACHE_WORDS_PER_LINE;
        if (exp_mem_ops.size() == 0) begin
            check_true(1'b0, "the bank issued a memory request that was not expected");
        end else begin
            exp = exp_mem_ops.pop_front();
            check_value("mem_req.write", op.write, exp.write);
            check_value("mem_req.addr", op.addr, exp.addr);
        end
        if (op.write) begin
            mem_writes++;
            for (int o = 0; o < `CACHE_WORDS_PER_LINE; o++) begin
                check_value("mem_req.data", op.data[o], arch_mem[base + o]);
                back_mem[base + o] = op.data[o];
            end
        end else begin
            mem_reads++;
            rd_pending = 1'b1;
            rd_addr    = op.addr;
            rd_wait    = latencies[mem_reads % 256];
        end
    endtask

    // Memory model that answers one read after its latency
    initial begin
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        rd_pending    = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            mem_rsp_valid = 1'b0;
            if (rd_pending) begin
                rd_wait--;
                if (rd_wait == 0) begin
                    rd_pending    = 1'b0;
                    mem_rsp_valid = 1'b1;
                    for (int o = 0; o < `CACHE_WORDS_PER_LINE; o++) begin
                        mem_rsp_data[o] = back_mem[int'(rd_addr) * `CACHE_WORDS_PER_LINE + o];
                    end
                end
            end
            if (mem_req_valid) begin
                serve_memory(mem_req);
            end
        end
    end

    task automatic report_test(int num, string name, int errs_before);
        $display("test %0d %s: %0d errors", num, name, errors - errs_before);
    endtask

    initial begin
        word_addr_t a;
        logic       hit;
        int         busy_cycles;
        int         wb_before;
        int         errs_before;
        int         pick;
        int         props_fails;
        void'($urandom(32'h1ae27eed));
        reset          = 1'b1;
        core_req_valid = 1'b0;
        core_req       = '0;
        checks         = 0;
        errors         = 0;
        mem_reads      = 0;
        mem_writes     = 0;
        ref_rr         = 0;
        for (int i = 0; i < 256; i++) begin
            latencies[i] = $urandom_range(8, 1);
        end
        for (int i = 0; i < NUM_WORDS; i++) begin
            arch_mem[i] = fill_pattern(i);
            back_mem[i] = fill_pattern(i);
        end
        for (int s = 0; s < `CACHE_NUM_LINES; s++) begin
            for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
                ref_tag[s][w]   = '0;
            end
        end

        // Init sweep followed by first reads of untouched lines
        errs_before = errors;
        repeat (3) @(posedge clk);
        #1;
        reset       = 1'b0;
        busy_cycles = 0;
        while (busy) begin
            busy_cycles++;
            @(posedge clk);
            #1;
        end
        check_value("init busy cycles", busy_cycles, `CACHE_NUM_LINES);
        for (int i = 0; i < INIT_READS; i++) begin
            a     = '0;
            a.tag = tag_t'(i);
            a.idx = line_idx_t'(12 + i);
            a.off = word_off_t'(i);
            issue(OP_READ, a, '0, '0, hit);
            check_true(!hit, "the first read of a line reported a hit");
        end
        report_test(1, "init and first reads", errs_before);

        errs_before = errors;
        for (int i = 0; i < RAND_READS; i++) begin
            issue(OP_READ, rand_addr(6, 0, 2), '0, '0, hit);
        end
        report_test(2, "random reads", errs_before);

        errs_before = errors;
        for (int i = 0; i < RAND_WRITES; i++) begin
            a = rand_addr(6, 2, 2);
            issue(OP_WRITE, a, $urandom, '0, hit);
            issue(OP_READ, a, '0, '0, hit);
        end
        report_test(3, "write then read", errs_before);

        // Four write misses fill set 9 and the fifth evicts a dirty way
        errs_before = errors;
        wb_before   = mem_writes;
        for (int t = 0; t < 5; t++) begin
            a     = '0;
            a.tag = tag_t'(8 + t);
            a.idx = line_idx_t'(9);
            a.off = word_off_t'(t);
            issue(OP_WRITE, a, $urandom, '0, hit);
        end
        check_value("victim writebacks", mem_writes - wb_before, 1);
        report_test(4, "dirty eviction", errs_before);

        errs_before = errors;
        a           = '0;
        a.tag       = tag_t'(20);
        a.idx       = line_idx_t'(11);
        a.off       = word_off_t'(2);
        issue(OP_WRITE, a, 32'hd00dfeed, '0, hit);
        wb_before = mem_writes;
        issue(OP_FLUSH, a, '0, '1, hit);
        check_value("flush writebacks", mem_writes - wb_before, 1);
        issue(OP_READ, a, '0, '0, hit);
        check_true(!hit, "a read after a flush reported a hit");
        report_test(5, "flush of a dirty line", errs_before);

        errs_before = errors;
        for (int i = 0; i < MIXED_OPS; i++) begin
            pick = $urandom_range(99, 0);
            a    = rand_addr(8, 0, `CACHE_NUM_LINES);
            if (pick < 45) begin
                issue(OP_READ, a, '0, '0, hit);
            end else if (pick < 90) begin
                issue(OP_WRITE, a, $urandom, '0, hit);
            end else begin
                issue(OP_FLUSH, a, '0, way_mask_t'($urandom_range(15, 1)), hit);
            end
        end
        // Write back every dirty line so that memory holds all data
        for (int s = 0; s < `CACHE_NUM_LINES; s++) begin
            a     = '0;
            a.idx = line_idx_t'(s);
            issue(OP_FLUSH, a, '0, '1, hit);
        end
        for (int i = 0; i < NUM_WORDS; i++) begin
            check_value($sformatf("back_mem[%0d]", i), back_mem[i], arch_mem[i]);
        end
        report_test(6, "mixed random run", errs_before);

        // Let the last response's properties complete
        repeat (2) @(posedge clk);
        #1;
        props_fails = i_cache_bank.i_props.assert_fails;
        $display("%0d checks, %0d errors, %0d assertion failures", checks, errors, props_fails);
        if (errors == 0 && props_fails == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+design
design/cache_addr_pkg.sv
design/cache_req_pkg.sv
design/cache_tags.sv
design/cache_data.sv
design/cache_bank_ctrl.sv
design/cache_bank.sv
test/cache_bank_properties.sv
test/cache_bank_tb.sv

// File: Bender.yml
package:
  name: cache_bank

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/cache_addr_pkg.sv
      - design/cache_req_pkg.sv
      - design/cache_tags.sv
      - design/cache_data.sv
      - design/cache_bank_ctrl.sv
      - design/cache_bank.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/cache_bank_properties.sv
      - test/cache_bank_tb.sv
